// File: sim.f
src/Types.sv
src/DataMemoryBus.sv
src/ram1024x8.sv
src/DataMemory1024x32.sv
src/LoadStoreUnit.sv
src/DataMemorySubsystem.sv
verification/DataMemorySubsystem_sva.sv
verification/DataMemoryTb.sv

// File: Bender.yml
package:
  name: data_memory_subsystem

sources:
  # RTL, in compile order.
  - files:
      - src/Types.sv
      - src/DataMemoryBus.sv
      - src/ram1024x8.sv
      - src/DataMemory1024x32.sv
      - src/LoadStoreUnit.sv
      - src/DataMemorySubsystem.sv

  # Testbench and bound assertions.
  - target: simulation
    files:
      - verification/DataMemorySubsystem_sva.sv
      - verification/DataMemoryTb.sv

// File: verification/DataMemoryTb.sv
`timescale 1ns/1ps

module DataMemoryTb
    import Types::*;
();

    localparam int ResetCycles  = 16;
    localparam int PreloadWords = 64;
    // Preload, about 2000 random requests, then margin.
    localparam int MaxCycles    = 4000;

    typedef struct {
        logic valid;
        logic fault;
        logic known;
        Data  data;
    } Expected;

    logic      clock;
    logic      rstN;
    logic      req;
    logic      write;
    DataAccess access;
    logic      isUnsigned;
    Addr       addr;
    Data       wrData;
    logic      loadValid;
    Data       loadData;
    logic      accessFault;

    logic [31:0] rngState = 32'hc3a8_ab9a;
    int          cycleCount = 0;
    logic [7:0]  modelMem [256];
    logic        modelValid [256];
    Expected     pending [$];

    DataMemorySubsystem i_dut (
        .clock       (clock),
        .rstN        (rstN),
        .req         (req),
        .write       (write),
        .access      (access),
        .isUnsigned  (isUnsigned),
        .addr        (addr),
        .wrData      (wrData),
        .loadValid   (loadValid),
        .loadData    (loadData),
        .accessFault (accessFault)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    initial begin
        while (cycleCount < MaxCycles) begin
            @(posedge clock);
            cycleCount++;
        end
        stopWithFailure("timeout, the run did not finish within the cycle limit");
    end

    // **********************************************************************
    // Helpers.
    // **********************************************************************

    task automatic stopWithFailure(string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkData(string name, Data expected, Data actual);
        if (actual !== expected) begin
            stopWithFailure($sformatf("error at %0t: %s expected %h, actual %h",
                $time, name, expected, actual));
        end
    endtask

    task automatic checkBit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            stopWithFailure($sformatf("error at %0t: %s expected %b, actual %b",
                $time, name, expected, actual));
        end
    endtask

    function automatic Data nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    // High bits only; the low LCG bits repeat quickly.
    function automatic int randBelow(int n);
        Data r;
        r = nextRand();
        return int'(r[31:16]) % n;
    endfunction

    function automatic Addr alignFor(DataAccess acc, Addr a);
        case (acc)
            DataAccess_Half: return {a[31:1], 1'b0};
            DataAccess_Word: return {a[31:2], 2'b00};
            default:         return a;
        endcase
    endfunction

    task automatic modelStore(DataAccess acc, Addr a, Data d);
        int n;
        int i;
        n = (acc == DataAccess_Word) ? 4 : (acc == DataAccess_Half) ? 2 : 1;
        for (i = 0; i < n; i++) begin
            modelMem[a[7:0] + i]   = d[8*i +: 8];
            modelValid[a[7:0] + i] = 1'b1;
        end
    endtask

    function automatic Expected modelLoad(DataAccess acc, logic uns, Addr a);
        Expected     e;
        DataWord     w;
        logic [7:0]  base;
        logic [7:0]  b;
        logic [15:0] h;
        int          i;
        base    = {a[7:2], 2'b00};
        e.valid = 1'b1;
        e.fault = 1'b0;
        e.known = 1'b1;
        for (i = 0; i < 4; i++) begin
            w.bytes[i] = modelMem[base + i];
            e.known    = e.known & modelValid[base + i];
        end
        case (acc)
            DataAccess_Byte: begin
                b      = w.bytes[a[1:0]];
                e.data = uns ? {24'h0, b} : {{24{b[7]}}, b};
            end
            DataAccess_Half: begin
                h      = w.half[a[1]];
                e.data = uns ? {16'h0, h} : {{16{h[15]}}, h};
            end
            default: begin
                e.data = w.word;
            end
        endcase
        return e;
    endfunction

    // Checks the result due now and drives the next request.
    task automatic issue(logic doReq, logic doWrite, DataAccess acc, logic uns, Addr a,
                         Data d);
        Expected e;
        logic    mis;
        @(negedge clock);
        if (pending.size() == 2) begin
            e = pending.pop_front();
            checkBit("loadValid", e.valid, loadValid);
            checkBit("accessFault", e.fault, accessFault);
            if (e.valid && e.known) begin
                checkData("loadData", e.data, loadData);
            end
        end
        if (i_dut.props.failCount != 0) begin
            stopWithFailure("a bound assertion on the DUT failed");
        end
        req        = doReq;
        write      = doWrite;
        access     = acc;
        isUnsigned = uns;
        addr       = a;
        wrData     = d;
        mis     = (acc == DataAccess_Half && a[0]) ||
                  (acc == DataAccess_Word && a[1:0] != 2'b00);
        e.valid = 1'b0;
        e.fault = doReq && mis;
        e.known = 1'b0;
        e.data  = '0;
        if (doReq && !mis) begin
            if (doWrite) begin
                modelStore(acc, a, d);
            end else begin
                e = modelLoad(acc, uns, a);
            end
        end
        pending.push_back(e);
    endtask

    task automatic idle();
        issue(1'b0, 1'b0, DataAccess_Byte, 1'b0, '0, '0);
    endtask

    // **********************************************************************
    // Stimulus.
    // **********************************************************************

    initial begin
        Addr       a;
        DataAccess acc;
        int        kind;
        int        i;
        req        = 1'b0;
        write      = 1'b0;
        access     = DataAccess_Byte;
        isUnsigned = 1'b0;
        addr       = '0;
        wrData     = '0;
        rstN       = 1'b0;
        for (i = 0; i < 256; i++) begin
            modelValid[i] = 1'b0;
        end
        repeat (ResetCycles) begin
            @(negedge clock);
            checkBit("loadValid", 1'b0, loadValid);
            checkBit("accessFault", 1'b0, accessFault);
        end
        rstN = 1'b1;

        // Word preload and readback.
        for (i = 0; i < PreloadWords; i++) begin
            issue(1'b1, 1'b1, DataAccess_Word, 1'b0, Addr'(4 * i), nextRand());
        end
        for (i = 0; i < PreloadWords; i++) begin
            issue(1'b1, 1'b0, DataAccess_Word, 1'b0, Addr'(4 * i), '0);
        end

        // Partial stores, each checked by a word load.
        for (i = 0; i < 300; i++) begin
            acc = DataAccess'(2'(randBelow(2)));
            a   = alignFor(acc, Addr'(randBelow(256)));
            issue(1'b1, 1'b1, acc, 1'b0, a, nextRand());
            issue(1'b1, 1'b0, DataAccess_Word, 1'b0, alignFor(DataAccess_Word, a), '0);
        end

        // Byte and half loads, signed and unsigned.
        for (i = 0; i < 400; i++) begin
            acc = DataAccess'(2'(randBelow(2)));
            a   = alignFor(acc, Addr'(randBelow(256)));
            issue(1'b1, 1'b0, acc, 1'(randBelow(2)), a, '0);
        end

        // Misaligned requests.
        for (i = 0; i < 200; i++) begin
            acc  = DataAccess'(2'(1 + randBelow(2)));
            a    = Addr'(randBelow(256));
            a    = (acc == DataAccess_Half) ? (a | 32'h1) : {a[31:2], 2'(1 + randBelow(3))};
            kind = randBelow(2);
            issue(1'b1, 1'(kind), acc, 1'(randBelow(2)), a, nextRand());
            if (kind == 1) begin
                issue(1'b1, 1'b0, DataAccess_Word, 1'b0, alignFor(DataAccess_Word, a), '0);
            end
        end

        // Back-to-back mixed traffic.
        for (i = 0; i < 500; i++) begin
            kind = randBelow(8);
            acc  = DataAccess'(2'(randBelow(3)));
            a    = alignFor(acc, Addr'(randBelow(256)));
            if (kind == 0) begin
                idle();
            end else if (kind <= 3) begin
                issue(1'b1, 1'b1, acc, 1'b0, a, nextRand());
            end else if (kind <= 6) begin
                issue(1'b1, 1'b0, acc, 1'(randBelow(2)), a, '0);
            end else begin
                issue(1'b1, 1'b1, acc, 1'b0, a, nextRand());
                issue(1'b1, 1'b0, DataAccess_Word, 1'b0, alignFor(DataAccess_Word, a), '0);
            end
        end

        // Let the last results and their assertions come through.
        repeat (4) begin
            idle();
        end
        if (i_dut.props.failCount == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stopWithFailure("a bound assertion on the DUT failed");
        end
    end

endmodule

// File: verification/DataMemorySubsystem_sva.sv
`timescale 1ns/1ps

module DataMemorySubsystem_sva
    import Types::*;
(
    input logic      clock,
    input logic      rstN,
    input logic      req,
    input logic      write,
    input DataAccess access,
    input Addr       addr,
    input logic      busWr,
    input logic      loadValid,
    input logic      accessFault
);

    int   failCount = 0;
    logic misaligned;
    logic alignedLoad;

    assign misaligned = (access == DataAccess_Half && addr[0]) ||
                        (access == DataAccess_Word && addr[1:0] != 2'b00);
    assign alignedLoad = req && !write && !misaligned;

    strobesExclusive: assert property (@(posedge clock) disable iff (!rstN)
        !(loadValid && accessFault))
    else begin
        failCount++;
        $error("loadValid and accessFault are high together");
    end

    // Result two edges after the request edge.
    loadFollowsRequest: assert property (@(posedge clock) disable iff (!rstN)
        alignedLoad |-> ##2 loadValid)
    else begin
        failCount++;
        $error("aligned load gave no loadValid");
    end

    loadHasRequest: assert property (@(posedge clock) disable iff (!rstN)
        loadValid |-> $past(alignedLoad, 2))
    else begin
        failCount++;
        $error("loadValid without an aligned load");
    end

    noMisalignedWrite: assert property (@(posedge clock)
        req && misaligned |-> !busWr)
    else begin
        failCount++;
        $error("write strobe on a misaligned request");
    end

    quietInReset: assert property (@(posedge clock)
        !rstN |-> !loadValid && !accessFault)
    else begin
        failCount++;
        $error("result strobe high during reset");
    end

endmodule

bind DataMemorySubsystem DataMemorySubsystem_sva props (
    .clock       (clock),
    .rstN        (rstN),
    .req         (req),
    .write       (write),
    .access      (access),
    .addr        (addr),
    .busWr       (memBus.wr),
    .loadValid   (loadValid),
    .accessFault (accessFault)
);

// File: src/DataMemorySubsystem.sv
`timescale 1ns/1ps

module DataMemorySubsystem
    import Types::*;
(
    input  logic      clock,
    input  logic      rstN,
    input  logic      req,
    input  logic      write,
    input  DataAccess access,
    input  logic      isUnsigned,
    input  Addr       addr,
    input  Data       wrData,
    output logic      loadValid,
    output Data       loadData,
    output logic      accessFault
);

    // Processor to memory link.
    DataMemoryBus memBus ();

    LoadStoreUnit lsu (
        .clock       (clock),
        .rstN        (rstN),
        .req         (req),
        .write       (write),
        .access      (access),
        .isUnsigned  (isUnsigned),
        .addr        (addr),
        .wrData      (wrData),
        .loadValid   (loadValid),
        .loadData    (loadData),
        .accessFault (accessFault),
        .bus         (memBus.master)
    );

    DataMemory1024x32 dataMem (
        .clock (clock),
        .bus   (memBus.slave)
    );

endmodule

// File: src/LoadStoreUnit.sv
`timescale 1ns/1ps

module LoadStoreUnit
    import Types::*;
(
    input  logic         clock,
    input  logic         rstN,
    input  logic         req,
    input  logic         write,
    input  DataAccess    access,
    input  logic         isUnsigned,
    input  Addr          addr,
    input  Data          wrData,
    output logic         loadValid,
    output Data          loadData,
    output logic         accessFault,
    DataMemoryBus.master bus
);

    logic      misaligned;
    logic      pendLoad;
    logic      pendFault;
    DataAccess pendAccess;
    logic [1:0] pendOffset;
    logic      pendUnsigned;
    DataWord   rdWord;
    logic      fill;
    Data       extended;

    // ******************************************************************
    // Request side.
    // ******************************************************************

    always_comb begin
        case (access)
            DataAccess_Half: misaligned = addr[0];
            DataAccess_Word: misaligned = |addr[1:0];
            default:         misaligned = 1'b0;
        endcase
    end

    assign bus.addr   = addr;
    assign bus.access = access;
    assign bus.wrData = wrData;

    // Only aligned stores reach the RAM.
    assign bus.wr = req & write & ~misaligned;

    // Stage one: request seen, RAM read under way.
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pendLoad  <= 1'b0;
            pendFault <= 1'b0;
        end else begin
            pendLoad  <= req & ~write & ~misaligned;
            pendFault <= req & misaligned;
        end
    end

    always_ff @(posedge clock) begin
        if (req && !write) begin
            pendAccess   <= access;
            pendOffset   <= addr[1:0];
            pendUnsigned <= isUnsigned;
        end
    end

    // ******************************************************************
    // Load extraction.
    // ******************************************************************

    assign rdWord = bus.rdData;

    always_comb begin
        fill     = 1'b0;
        extended = rdWord.word;
        case (pendAccess)
            DataAccess_Byte: begin
                fill     = ~pendUnsigned & rdWord.bytes[pendOffset][7];
                extended = {{24{fill}}, rdWord.bytes[pendOffset]};
            end
            DataAccess_Half: begin
                fill     = ~pendUnsigned & rdWord.half[pendOffset[1]][15];
                extended = {{16{fill}}, rdWord.half[pendOffset[1]]};
            end
            default: begin
                extended = rdWord.word;
            end
        endcase
    end

    // Stage two: result strobes.
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            loadValid   <= 1'b0;
            accessFault <= 1'b0;
        end else begin
            loadValid   <= pendLoad;
            accessFault <= pendFault;
        end
    end

    always_ff @(posedge clock) begin
        if (pendLoad) begin
            loadData <= extended;
        end
    end

endmodule

// File: src/DataMemory1024x32.sv
`timescale 1ns/1ps

module DataMemory1024x32
    import Types::*;
(
    input  logic        clock,
    DataMemoryBus.slave bus
);

    logic [LaneAddrBits-1:0] wordAddr;
    logic [3:0]              laneEn;
    logic [3:0]              laneWr;
    Data                     steered;
    Data                     rdWord;

    assign wordAddr = bus.addr[LaneAddrBits+1:2];

    // ******************************************************************
    // Write steering.
    // ******************************************************************

    always_comb begin
        laneEn  = 4'b0000;
        steered = bus.wrData;
        case (bus.access)
            DataAccess_Byte: begin
                // Byte is copied to every lane, one lane enabled.
                steered = {4{bus.wrData[7:0]}};
                laneEn  = 4'b0001 << bus.addr[1:0];
            end
            DataAccess_Half: begin
                steered = {2{bus.wrData[15:0]}};
                laneEn  = bus.addr[1] ? 4'b1100 : 4'b0011;
            end
            DataAccess_Word: begin
                steered = bus.wrData;
                laneEn  = 4'b1111;
            end
            default: begin
                laneEn = 4'b0000;
            end
        endcase
    end

    assign laneWr = laneEn & {4{bus.wr}};

    // ******************************************************************
    // Byte lanes.
    // ******************************************************************

    ram1024x8 ram0 (
        .clock   (clock),
        .address (wordAddr),
        .wren    (laneWr[0]),
        .data    (steered[7:0]),
        .q       (rdWord[7:0])
    );

    ram1024x8 ram1 (
        .clock   (clock),
        .address (wordAddr),
        .wren    (laneWr[1]),
        .data    (steered[15:8]),
        .q       (rdWord[15:8])
    );

    ram1024x8 ram2 (
        .clock   (clock),
        .address (wordAddr),
        .wren    (laneWr[2]),
        .data    (steered[23:16]),
        .q       (rdWord[23:16])
    );

    ram1024x8 ram3 (
        .clock   (clock),
        .address (wordAddr),
        .wren    (laneWr[3]),
        .data    (steered[31:24]),
        .q       (rdWord[31:24])
    );

    // Full word back; the master picks its part.
    assign bus.rdData = rdWord;

endmodule

// File: src/ram1024x8.sv
`timescale 1ns/1ps

module ram1024x8
    import Types::*;
(
    input  logic                    clock,
    input  logic [LaneAddrBits-1:0] address,
    input  logic                    wren,
    input  logic [7:0]              data,
    output logic [7:0]              q
);

    // Lane storage.
    logic [7:0] mem [MemWords];

    // Write on the edge, register the old entry into q.
    always_ff @(posedge clock) begin
        if (wren) begin
            mem[address] <= data;
        end
        q <= mem[address];
    end

endmodule

// File: src/DataMemoryBus.sv
`timescale 1ns/1ps

interface DataMemoryBus
    import Types::*;
();

    Addr       addr;
    DataAccess access;
    logic      wr;
    Data       wrData;
    Data       rdData;

    // Load/store unit side.
    modport master (
        output addr,
        output access,
        output wr,
        output wrData,
        input  rdData
    );

    // Memory side.
    modport slave (
        input  addr,
        input  access,
        input  wr,
        input  wrData,
        output rdData
    );

endinterface

// File: src/Types.sv
package Types;

    // ******************************************************************
    // Memory geometry.
    // ******************************************************************

    // Words in the data memory.
    localparam int MemWords = 1024;

    // Width of the word address inside each lane.
    localparam int LaneAddrBits = 10;

    // ******************************************************************
    // Data types.
    // ******************************************************************

    // Access size of a memory request.
    typedef enum logic [1:0] {
        DataAccess_Byte = 2'b00,
        DataAccess_Half = 2'b01,
        DataAccess_Word = 2'b10
    } DataAccess;

    typedef logic [31:0] Data;

    // Byte address.
    typedef logic [31:0] Addr;

    // One memory word seen whole, by halves or by bytes.
    typedef union packed {
        Data              word;
        logic [1:0][15:0] half;
        logic [3:0][7:0]  bytes;
    } DataWord;

endpackage
